//--- src/vec_rename_pkg.sv
/*
 * Shared sizes and types of the vector configuration rename block.
 * The vsetvl unit, the rename ring and the top level import this package.
 */
`default_nettype none

package vec_rename_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  // vector register length in bits
  localparam int VLEN = 128;
  // vl reaches VLEN at SEW 8 and LMUL 8, so it needs one extra bit
  localparam int VL_W = $clog2(VLEN) + 1;

  // rename ring depth
  localparam int VLVTYPE_REN_SIZE = 8;
  localparam int VLVTYPE_REN_IDX_W = $clog2(VLVTYPE_REN_SIZE);

  // ----------------------------------------------------------------------
  // plain vector types
  // ----------------------------------------------------------------------
  typedef logic [VLVTYPE_REN_IDX_W-1:0] vlvtype_ren_idx_t;
  typedef logic [VL_W-1:0]              vl_t;
  typedef logic [31:0]                  avl_t;

  // ----------------------------------------------------------------------
  // structs
  // ----------------------------------------------------------------------
  // vlmul follows the RISC-V encoding, 4 is reserved
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // value of one rename entry
  typedef struct packed {
    vl_t    vl;
    vtype_t vtype;
  } vlvtype_t;

  // result of the vsetvl unit for the entry it was allocated
  typedef struct packed {
    logic             valid;
    vlvtype_ren_idx_t index;
    vlvtype_t         vlvtype;
  } vlvtype_upd_t;

endpackage

`default_nettype wire

//--- src/vsetvl_unit.sv
/*
 * One-stage vsetvl execution. Derives vlmax from SEW and LMUL, clamps the
 * application vector length to it, and flags unsupported settings with
 * vill. The result leaves one cycle after issue as a table update.
 */
`timescale 1ns/10ps
`default_nettype none

module vsetvl_unit (
  input  wire logic                               i_clk,
  input  wire logic                               i_reset_n,

  // issue from the scheduler
  input  wire logic                               i_issue_valid,
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_issue_index,
  input  wire vec_rename_pkg::avl_t               i_issue_avl,
  input  wire vec_rename_pkg::vtype_t             i_issue_vtype,

  // result to the rename table
  output vec_rename_pkg::vlvtype_upd_t            o_upd
);

  import vec_rename_pkg::*;

  vl_t              w_vlmax_sew;
  vl_t              w_vlmax;
  logic             w_sew_legal;
  logic             w_lmul_legal;
  logic             w_illegal;
  vlvtype_t         w_result;

  logic             r_upd_valid;
  vlvtype_ren_idx_t r_upd_index;
  vlvtype_t         r_upd_vlvtype;

  // ----------------------------------------------------------------------
  // vlmax for LMUL 1
  // ----------------------------------------------------------------------
  always_comb begin
    w_sew_legal = 1'b1;
    case (i_issue_vtype.vsew)
      3'd0:    w_vlmax_sew = vl_t'(VLEN / 8);
      3'd1:    w_vlmax_sew = vl_t'(VLEN / 16);
      3'd2:    w_vlmax_sew = vl_t'(VLEN / 32);
      3'd3:    w_vlmax_sew = vl_t'(VLEN / 64);
      default: begin
        // wider than 64 bits is not supported
        w_vlmax_sew = '0;
        w_sew_legal = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // scale by LMUL
  // ----------------------------------------------------------------------
  always_comb begin
    w_lmul_legal = 1'b1;
    case (i_issue_vtype.vlmul)
      3'd0:    w_vlmax = w_vlmax_sew;
      3'd1:    w_vlmax = w_vlmax_sew << 1;
      3'd2:    w_vlmax = w_vlmax_sew << 2;
      3'd3:    w_vlmax = w_vlmax_sew << 3;
      // fractional, 1/8 .. 1/2
      3'd5:    w_vlmax = w_vlmax_sew >> 3;
      3'd6:    w_vlmax = w_vlmax_sew >> 2;
      3'd7:    w_vlmax = w_vlmax_sew >> 1;
      default: begin
        w_vlmax      = '0;
        w_lmul_legal = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // new vl and vtype
  // ----------------------------------------------------------------------
  // zero vlmax only comes from a fraction too small for this SEW
  assign w_illegal = !w_sew_legal || !w_lmul_legal || (w_vlmax == '0);

  always_comb begin
    w_result = '0;
    if (w_illegal) begin
      w_result.vtype.vill = 1'b1;
    end else begin
      w_result.vtype      = i_issue_vtype;
      w_result.vtype.vill = 1'b0;
      if (i_issue_avl < avl_t'(w_vlmax)) begin
        w_result.vl = vl_t'(i_issue_avl);
      end else begin
        w_result.vl = w_vlmax;
      end
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_upd_valid <= 1'b0;
    end else begin
      r_upd_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid) begin
      r_upd_index   <= i_issue_index;
      r_upd_vlvtype <= w_result;
    end
  end

  assign o_upd.valid   = r_upd_valid;
  assign o_upd.index   = r_upd_index;
  assign o_upd.vlvtype = r_upd_vlvtype;

endmodule

`default_nettype wire

//--- src/vlvtype_rename.sv
/*
 * Rename ring of vl/vtype entries. A dispatched vsetvl allocates the head
 * entry and makes it current, the vsetvl unit fills it in later, and
 * commits retire entries in order. CSR reads index the table directly.
 */
`timescale 1ns/10ps
`default_nettype none

module vlvtype_rename (
  input  wire logic                               i_clk,
  input  wire logic                               i_reset_n,

  // allocation from dispatch
  input  wire logic                               i_req_valid,
  output logic                                    o_req_full,
  output logic                                    o_req_ready,
  output vec_rename_pkg::vlvtype_ren_idx_t        o_req_index,
  output vec_rename_pkg::vlvtype_ren_idx_t        o_req_vsetvl_index,
  output vec_rename_pkg::vlvtype_t                o_req_vlvtype,

  // result of the vsetvl unit
  input  wire vec_rename_pkg::vlvtype_upd_t       i_upd,

  // in-order commit
  input  wire logic                               i_cmt_valid,
  input  wire logic                               i_cmt_dead,

  // csr read port
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_csr_index,
  output vec_rename_pkg::vlvtype_t                o_csr_vlvtype
);

  import vec_rename_pkg::*;

  typedef logic [VLVTYPE_REN_SIZE-1:0] ren_flags_t;

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------
  vlvtype_t         r_table [VLVTYPE_REN_SIZE];
  ren_flags_t       r_table_valid;
  ren_flags_t       r_table_ready;

  // head is the next free entry, curr the newest allocated one
  vlvtype_ren_idx_t r_head_ptr;
  vlvtype_ren_idx_t r_curr_index;
  vlvtype_ren_idx_t r_committed_ptr;

  logic             w_alloc;
  vlvtype_ren_idx_t w_cmt_next;

  assign o_req_full = &r_table_valid;
  assign w_alloc    = i_req_valid && !o_req_full;
  assign w_cmt_next = r_committed_ptr + vlvtype_ren_idx_t'(1);

  // ----------------------------------------------------------------------
  // pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_ptr      <= vlvtype_ren_idx_t'(1);
      r_curr_index    <= '0;
      r_committed_ptr <= '0;
    end else begin
      if (w_alloc) begin
        r_head_ptr   <= r_head_ptr + vlvtype_ren_idx_t'(1);
        r_curr_index <= r_head_ptr;
      end
      if (i_cmt_valid) begin
        r_committed_ptr <= w_cmt_next;
      end
    end
  end

  // ----------------------------------------------------------------------
  // per-entry flags
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // only entry 0 holds a live configuration out of reset
      r_table_valid <= ren_flags_t'(1);
      r_table_ready <= ren_flags_t'(1);
    end else begin
      // retiring entry hands its flags to its successor
      if (i_cmt_valid) begin
        r_table_valid[r_committed_ptr] <= 1'b0;
        r_table_ready[r_committed_ptr] <= 1'b0;
        r_table_valid[w_cmt_next] <= r_table_valid[w_cmt_next] |
                                     r_table_valid[r_committed_ptr];
        r_table_ready[w_cmt_next] <= r_table_ready[w_cmt_next] |
                                     r_table_ready[r_committed_ptr];
      end

      if (w_alloc) begin
        r_table_valid[r_head_ptr] <= 1'b1;
        r_table_ready[r_head_ptr] <= 1'b0;
      end

      if (i_upd.valid) begin
        r_table_ready[i_upd.index] <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // entry values
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < VLVTYPE_REN_SIZE; i++) begin
        r_table[i] <= '0;
      end
    end else begin
      // squashed vsetvl, the next entry falls back to the older value
      if (i_cmt_valid && i_cmt_dead) begin
        r_table[w_cmt_next] <= r_table[r_committed_ptr];
      end
      // a computed result wins over the copy on the same entry
      if (i_upd.valid) begin
        r_table[i_upd.index] <= i_upd.vlvtype;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------
  assign o_req_index        = r_curr_index;
  assign o_req_vsetvl_index = r_head_ptr;
  assign o_req_ready        = r_table_ready[r_curr_index];
  assign o_req_vlvtype      = r_table[r_curr_index];

  assign o_csr_vlvtype = r_table[i_csr_index];

endmodule

`default_nettype wire

//--- src/vec_rename_top.sv
/*
 * Top level of the vector configuration rename block. The vsetvl unit
 * feeds its results into the rename ring, which serves dispatch, commit
 * and CSR reads.
 */
`timescale 1ns/10ps
`default_nettype none

module vec_rename_top (
  input  wire logic                               i_clk,
  input  wire logic                               i_reset_n,

  // dispatch of a vsetvl
  input  wire logic                               i_req_valid,
  output logic                                    o_req_full,
  output logic                                    o_req_ready,
  output vec_rename_pkg::vlvtype_ren_idx_t        o_req_index,
  output vec_rename_pkg::vlvtype_ren_idx_t        o_req_vsetvl_index,
  output vec_rename_pkg::vlvtype_t                o_req_vlvtype,

  // vsetvl issue
  input  wire logic                               i_issue_valid,
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_issue_index,
  input  wire vec_rename_pkg::avl_t               i_issue_avl,
  input  wire vec_rename_pkg::vtype_t             i_issue_vtype,

  // commit
  input  wire logic                               i_cmt_valid,
  input  wire logic                               i_cmt_dead,

  // csr read
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_csr_index,
  output vec_rename_pkg::vlvtype_t                o_csr_vlvtype
);

  import vec_rename_pkg::*;

  // one-cycle update from the execution stage
  vlvtype_upd_t upd;

  // ----------------------------------------------------------------------
  // execution
  // ----------------------------------------------------------------------
  vsetvl_unit u_vsetvl_unit (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_issue_index (i_issue_index),
    .i_issue_avl   (i_issue_avl),
    .i_issue_vtype (i_issue_vtype),
    .o_upd         (upd)
  );

  // ----------------------------------------------------------------------
  // rename ring
  // ----------------------------------------------------------------------
  vlvtype_rename u_vlvtype_rename (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_req_valid        (i_req_valid),
    .o_req_full         (o_req_full),
    .o_req_ready        (o_req_ready),
    .o_req_index        (o_req_index),
    .o_req_vsetvl_index (o_req_vsetvl_index),
    .o_req_vlvtype      (o_req_vlvtype),
    .i_upd              (upd),
    .i_cmt_valid        (i_cmt_valid),
    .i_cmt_dead         (i_cmt_dead),
    .i_csr_index        (i_csr_index),
    .o_csr_vlvtype      (o_csr_vlvtype)
  );

endmodule

`default_nettype wire

//--- verification/vec_rename_assertions.sv
/*
 * Concurrent checks on the pointers and flags of the rename ring.
 * Bound into every vlvtype_rename instance.
 */
`timescale 1ns/10ps
`default_nettype none

module vlvtype_rename_assertions (
  input  wire logic                               i_clk,
  input  wire logic                               i_reset_n,
  input  wire logic                               i_req_valid,
  input  wire logic                               i_req_full,
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_head_ptr,
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_curr_index,
  input  wire vec_rename_pkg::vlvtype_ren_idx_t   i_committed_ptr
);

  import vec_rename_pkg::*;

  // a request against a full ring must not move the head
  a_no_alloc_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_req_valid && i_req_full) |=> (i_head_ptr == $past(i_head_ptr)))
    else $error("allocation taken while the rename ring was full");

  // head meets the committed pointer only when every entry is in use
  a_head_vs_committed: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ((i_head_ptr == i_committed_ptr) == i_req_full))
    else $error("head pointer caught up with the committed pointer");

  // newest entry sits right behind the head
  a_curr_trails_head: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_curr_index == vlvtype_ren_idx_t'(i_head_ptr - 3'd1)))
    else $error("current index does not trail the head pointer by one");

endmodule

bind vlvtype_rename vlvtype_rename_assertions u_rename_assertions (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_req_valid     (i_req_valid),
  .i_req_full      (o_req_full),
  .i_head_ptr      (r_head_ptr),
  .i_curr_index    (r_curr_index),
  .i_committed_ptr (r_committed_ptr)
);

`default_nettype wire

//--- verification/tb_vec_rename.sv
/*
 * Random testbench for the vector configuration rename block. A model of
 * the ring and of the vl rule runs alongside the DUT and every output is
 * compared after each rising edge. Run it with the Makefile sim target.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_vec_rename;

  import vec_rename_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int RAND_CYCLES = 2000;
  // reset, ring fill, full probe and drain on top of the random cycles
  localparam int TIMEOUT_NS  = (RAND_CYCLES + 32) * CLK_PERIOD + 500;

  logic             i_clk;
  logic             i_reset_n;
  logic             i_req_valid;
  logic             i_issue_valid;
  vlvtype_ren_idx_t i_issue_index;
  avl_t             i_issue_avl;
  vtype_t           i_issue_vtype;
  logic             i_cmt_valid;
  logic             i_cmt_dead;
  vlvtype_ren_idx_t i_csr_index;
  logic             o_req_full;
  logic             o_req_ready;
  vlvtype_ren_idx_t o_req_index;
  vlvtype_ren_idx_t o_req_vsetvl_index;
  vlvtype_t         o_req_vlvtype;
  vlvtype_t         o_csr_vlvtype;

  // ----------------------------------------------------------------------
  // reference model state
  // ----------------------------------------------------------------------
  vlvtype_t                    m_table [VLVTYPE_REN_SIZE];
  logic [VLVTYPE_REN_SIZE-1:0] m_valid;
  logic [VLVTYPE_REN_SIZE-1:0] m_ready;
  vlvtype_ren_idx_t            m_head;
  vlvtype_ren_idx_t            m_curr;
  vlvtype_ren_idx_t            m_cmt;
  logic                        m_upd_valid;
  vlvtype_ren_idx_t            m_upd_index;
  vlvtype_t                    m_upd_value;

  // stimulus bookkeeping
  vlvtype_ren_idx_t            unissued [$];
  logic [VLVTYPE_REN_SIZE-1:0] issued;
  logic [1:0]                  follow_valid;
  vlvtype_ren_idx_t            follow_idx [2];

  vec_rename_top UUT (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_req_valid        (i_req_valid),
    .o_req_full         (o_req_full),
    .o_req_ready        (o_req_ready),
    .o_req_index        (o_req_index),
    .o_req_vsetvl_index (o_req_vsetvl_index),
    .o_req_vlvtype      (o_req_vlvtype),
    .i_issue_valid      (i_issue_valid),
    .i_issue_index      (i_issue_index),
    .i_issue_avl        (i_issue_avl),
    .i_issue_vtype      (i_issue_vtype),
    .i_cmt_valid        (i_cmt_valid),
    .i_cmt_dead         (i_cmt_dead),
    .i_csr_index        (i_csr_index),
    .o_csr_vlvtype      (o_csr_vlvtype)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("Error %s expected %h got %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // vlmax is VLEN / SEW scaled by LMUL and vl is the smaller of avl and vlmax
  function automatic vlvtype_t expected_vlvtype(input avl_t avl, input vtype_t vt);
    vlvtype_t res;
    int       sew_bits;
    int       lmul_code;
    int       vlmax;
    res       = '0;
    lmul_code = int'(vt.vlmul);
    if (vt.vsew > 3'd3 || lmul_code == 4) begin
      res.vtype.vill = 1'b1;
      return res;
    end
    sew_bits = 8 << int'(vt.vsew);
    if (lmul_code < 4) begin
      vlmax = (VLEN / sew_bits) * (1 << lmul_code);
    end else begin
      vlmax = VLEN / (sew_bits * (1 << (8 - lmul_code)));
    end
    if (vlmax == 0) begin
      res.vtype.vill = 1'b1;
      return res;
    end
    res.vtype      = vt;
    res.vtype.vill = 1'b0;
    res.vl         = (avl < avl_t'(vlmax)) ? vl_t'(avl) : vl_t'(vlmax);
    return res;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < VLVTYPE_REN_SIZE; i++) begin
      m_table[i] = '0;
    end
    m_valid     = 8'h01;
    m_ready     = 8'h01;
    m_head      = 3'd1;
    m_curr      = 3'd0;
    m_cmt       = 3'd0;
    m_upd_valid = 1'b0;
    m_upd_index = '0;
    m_upd_value = '0;
  endtask

  // one clock edge of the ring with all rules applied to the old state
  task automatic step_model();
    vlvtype_t                    nxt_table [VLVTYPE_REN_SIZE];
    logic [VLVTYPE_REN_SIZE-1:0] nxt_valid;
    logic [VLVTYPE_REN_SIZE-1:0] nxt_ready;
    vlvtype_ren_idx_t            cmt_next;
    nxt_table = m_table;
    nxt_valid = m_valid;
    nxt_ready = m_ready;
    cmt_next  = m_cmt + 3'd1;
    if (i_cmt_valid) begin
      nxt_valid[m_cmt]    = 1'b0;
      nxt_ready[m_cmt]    = 1'b0;
      nxt_valid[cmt_next] = m_valid[cmt_next] | m_valid[m_cmt];
      nxt_ready[cmt_next] = m_ready[cmt_next] | m_ready[m_cmt];
      if (i_cmt_dead) begin
        nxt_table[cmt_next] = m_table[m_cmt];
      end
    end
    if (i_req_valid && !(&m_valid)) begin
      nxt_valid[m_head] = 1'b1;
      nxt_ready[m_head] = 1'b0;
      m_curr            = m_head;
      m_head            = m_head + 3'd1;
    end
    // update from the previous edge's issue wins over the dead copy
    if (m_upd_valid) begin
      nxt_ready[m_upd_index] = 1'b1;
      nxt_table[m_upd_index] = m_upd_value;
    end
    if (i_cmt_valid) begin
      m_cmt = cmt_next;
    end
    m_upd_valid = i_issue_valid;
    if (i_issue_valid) begin
      m_upd_index = i_issue_index;
      m_upd_value = expected_vlvtype(i_issue_avl, i_issue_vtype);
    end
    m_table = nxt_table;
    m_valid = nxt_valid;
    m_ready = nxt_ready;
  endtask

  task automatic compare_outputs();
    check_value("o_req_full", 64'(&m_valid), 64'(o_req_full));
    check_value("o_req_index", 64'(m_curr), 64'(o_req_index));
    check_value("o_req_vsetvl_index", 64'(m_head), 64'(o_req_vsetvl_index));
    check_value("o_req_ready", 64'(m_ready[m_curr]), 64'(o_req_ready));
    check_value("o_req_vlvtype", 64'(m_table[m_curr]), 64'(o_req_vlvtype));
    check_value("o_csr_vlvtype", 64'(m_table[i_csr_index]), 64'(o_csr_vlvtype));
  endtask

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      step_model();
      #1;
      compare_outputs();
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  function automatic vtype_t random_vtype();
    vtype_t vt;
    vt.vill  = 1'($urandom_range(0, 1));
    vt.vma   = 1'($urandom_range(0, 1));
    vt.vta   = 1'($urandom_range(0, 1));
    vt.vsew  = 3'($urandom_range(0, 4));
    vt.vlmul = 3'($urandom_range(0, 7));
    return vt;
  endfunction

  function automatic avl_t random_avl();
    if ($urandom_range(0, 7) == 0) begin
      return $urandom();
    end
    return avl_t'($urandom_range(0, 2 * VLEN));
  endfunction

  task automatic clear_strobes();
    i_req_valid   = 1'b0;
    i_issue_valid = 1'b0;
    i_cmt_valid   = 1'b0;
    i_cmt_dead    = 1'b0;
  endtask

  task automatic drive_random();
    vlvtype_ren_idx_t cmt_next;
    vlvtype_ren_idx_t idx;
    int               pos;
    logic             issue_now;
    cmt_next  = m_cmt + 3'd1;
    idx       = '0;
    issue_now = 1'b0;
    clear_strobes();
    // oldest outstanding vsetvl retires once it was issued
    if (m_valid[cmt_next] && issued[cmt_next] && $urandom_range(0, 99) < 35) begin
      i_cmt_valid = 1'b1;
      i_cmt_dead  = ($urandom_range(0, 3) == 0);
    end
    if (unissued.size() > 0 && $urandom_range(0, 99) < 40) begin
      pos = int'($urandom_range(0, unissued.size() - 1));
      idx = unissued[pos];
      unissued.delete(pos);
      issued[idx]   = 1'b1;
      issue_now     = 1'b1;
      i_issue_valid = 1'b1;
      i_issue_index = idx;
      i_issue_avl   = random_avl();
      i_issue_vtype = random_vtype();
    end
    if (!(&m_valid) && $urandom_range(0, 99) < 45) begin
      i_req_valid    = 1'b1;
      issued[m_head] = 1'b0;
      unissued.push_back(m_head);
    end
    // look at the issued entry two cycles later once its result is in
    if (follow_valid[1]) begin
      i_csr_index = follow_idx[1];
    end else begin
      i_csr_index = vlvtype_ren_idx_t'($urandom_range(0, VLVTYPE_REN_SIZE - 1));
    end
    follow_valid[1] = follow_valid[0];
    follow_idx[1]   = follow_idx[0];
    follow_valid[0] = issue_now;
    follow_idx[0]   = idx;
  endtask

  initial begin
    void'($urandom(32'heb4e_8ffb));
    i_clk         = 1'b0;
    i_reset_n     = 1'b0;
    i_issue_index = '0;
    i_issue_avl   = '0;
    i_issue_vtype = '0;
    i_csr_index   = '0;
    issued        = '0;
    follow_valid  = '0;
    follow_idx[0] = '0;
    follow_idx[1] = '0;
    clear_strobes();
    reset_model();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // reset state
    check_value("o_req_index", 64'd0, 64'(o_req_index));
    check_value("o_req_vsetvl_index", 64'd1, 64'(o_req_vsetvl_index));
    check_value("o_req_ready", 64'd1, 64'(o_req_ready));
    check_value("o_req_vlvtype", 64'd0, 64'(o_req_vlvtype));
    check_value("o_req_full", 64'd0, 64'(o_req_full));

    // fill the ring without commits
    for (int n = 0; n < VLVTYPE_REN_SIZE - 1; n++) begin
      i_req_valid = 1'b1;
      unissued.push_back(m_head);
      @(negedge i_clk);
      clear_strobes();
    end
    check_value("o_req_full", 64'd1, 64'(o_req_full));
    // seven allocations from head 1 leave the newest at 7 and the head at 0
    i_req_valid = 1'b1;
    @(negedge i_clk);
    clear_strobes();
    check_value("o_req_index", 64'(VLVTYPE_REN_SIZE - 1), 64'(o_req_index));
    check_value("o_req_vsetvl_index", 64'd0, 64'(o_req_vsetvl_index));

    for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
      drive_random();
      @(negedge i_clk);
    end
    clear_strobes();
    repeat (4) @(negedge i_clk);
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, the run did not reach its end in time");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- filelist.f
src/vec_rename_pkg.sv
src/vsetvl_unit.sv
src/vlvtype_rename.sv
src/vec_rename_top.sv
verification/vec_rename_assertions.sv
verification/tb_vec_rename.sv

//--- Makefile
# Verilator build for the vector configuration rename block

TOP = tb_vec_rename

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
